// File: Bender.yml
package:
  name: prg_loader

sources:
  - files:
      - hw/loader_pkg.sv
      - hw/wb_if.sv
      - hw/load_sequencer.sv
      - hw/load_addr_counter.sv
      - hw/cart_block_map.sv
      - hw/wb_write_master.sv
      - hw/prg_loader_top.sv
  - target: test
    files:
      - tb/wb_mem_model.sv
      - tb/tb_prg_loader.sv

// File: hw/cart_block_map.sv
/*
 * Cartridge block map
 * One flag per 8 KB block written by a CRT load, plus the core reset hold
 */

`timescale 1ns/1ps

module cart_block_map (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  blk_mark,
	input  loader_pkg::addr_t     load_addr,
	input  logic                  crt_active,
	input  logic                  detach,
	input  logic                  cart_writable,
	output loader_pkg::blk_mask_t cart_blk,
	output loader_pkg::blk_mask_t cart_ro,
	output logic                  cart_reset
);

	function automatic loader_pkg::blk_mask_t block_of(input loader_pkg::addr_t addr);
		block_of = '0;
		case (addr[15:13])
			3'd0: block_of[0] = 1'b1;
			3'd1: block_of[1] = 1'b1;
			3'd2: block_of[2] = 1'b1;
			3'd3: block_of[3] = 1'b1;
			3'd5: block_of[4] = 1'b1;
			default: block_of = '0;
		endcase
	endfunction

	always_ff @(posedge clk_sys) begin
		if (reset || detach) begin
			cart_blk   <= '0;
			cart_reset <= 1'b0;
		end else begin
			cart_reset <= crt_active;
			if (blk_mark)
				cart_blk <= cart_blk | block_of(load_addr);
		end
	end

	// Writable cartridge RAM has no read-only blocks
	assign cart_ro = cart_writable ? '0 : cart_blk;

endmodule

// File: hw/load_addr_counter.sv
/*
 * File offset and load address counter
 * The offset restarts with each download, the load address comes from
 * the header and ends on the address after the last byte written
 */

`timescale 1ns/1ps

module load_addr_counter (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              cnt_start,
	input  logic              cnt_load_lo,
	input  logic              cnt_load_hi,
	input  logic              cnt_step,
	input  loader_pkg::byte_t dl_data,
	output loader_pkg::addr_t load_addr,
	output loader_pkg::addr_t file_offset
);

	logic offset_step;

	// Header bytes count as file bytes too
	assign offset_step = cnt_load_lo || cnt_load_hi || cnt_step;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			file_offset <= '0;
		end else if (cnt_start) begin
			file_offset <= '0;
		end else if (offset_step) begin
			file_offset <= file_offset + 16'd1;
		end
	end

	// Little endian header, low byte first
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			load_addr <= '0;
		end else begin
			if (cnt_load_lo)
				load_addr[7:0] <= dl_data;
			if (cnt_load_hi)
				load_addr[15:8] <= dl_data;
			if (cnt_step)
				load_addr <= load_addr + 16'd1;
		end
	end

endmodule

// File: hw/load_sequencer.sv
/*
 * Download sequencer
 * Decodes the file kind, routes header bytes to the address counter,
 * turns body bytes into write requests and patches BASIC pointers after PRG
 */

`timescale 1ns/1ps

module load_sequencer (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               dl_active,
	input  loader_pkg::byte_t  dl_index,
	input  logic               dl_valid,
	input  loader_pkg::byte_t  dl_data,
	output logic               dl_busy,
	input  loader_pkg::addr_t  file_offset,
	input  loader_pkg::addr_t  load_addr,
	output logic               cnt_load_lo,
	output logic               cnt_load_hi,
	output logic               cnt_step,
	output logic               cnt_start,
	output logic               wr_req,
	output loader_pkg::addr_t  wr_addr,
	output loader_pkg::byte_t  wr_data,
	input  logic               wr_busy,
	output logic               blk_mark,
	output logic               crt_active
);

	typedef enum logic [1:0] {
		st_idle,
		st_header,
		st_body,
		st_fixup
	} state_t;

	state_t                                     state;
	loader_pkg::load_kind_t                     kind;
	logic [$clog2(loader_pkg::num_fixups)-1:0] fix_idx;
	logic                                       start_pend;
	logic                                       take;
	logic                                       in_range;

	function automatic loader_pkg::load_kind_t decode_kind(input loader_pkg::byte_t idx);
		case (idx)
			loader_pkg::idx_prg: decode_kind = loader_pkg::kind_prg;
			loader_pkg::idx_crt: decode_kind = loader_pkg::kind_crt;
			loader_pkg::idx_rom: decode_kind = loader_pkg::kind_rom;
			default:             decode_kind = loader_pkg::kind_none;
		endcase
	endfunction

	// Core reset hold follows the download directly, not the latched kind
	assign crt_active = dl_active && (dl_index == loader_pkg::idx_crt);

	////////////////////////////////////////////////////////////
	// Stream handshake and request generation

	always_comb begin
		start_pend = (state == st_idle) && dl_active;
		dl_busy    = wr_busy || start_pend || (state == st_fixup);
		take       = dl_valid && dl_active && !dl_busy;

		case (kind)
			loader_pkg::kind_prg: in_range = load_addr < loader_pkg::prg_limit;
			loader_pkg::kind_crt: in_range = load_addr < loader_pkg::crt_limit;
			loader_pkg::kind_rom: in_range = (file_offset >= loader_pkg::rom_lo) &&
			                                 (file_offset < loader_pkg::rom_hi);
			default:              in_range = 1'b0;
		endcase

		cnt_start   = start_pend;
		cnt_load_lo = 1'b0;
		cnt_load_hi = 1'b0;
		cnt_step    = 1'b0;
		wr_req      = 1'b0;
		wr_addr     = load_addr;
		wr_data     = dl_data;
		blk_mark    = 1'b0;

		case (state)
			st_header: begin
				if (take) begin
					cnt_load_lo = !file_offset[0];
					cnt_load_hi = file_offset[0];
				end
			end
			st_body: begin
				if (take) begin
					wr_req   = in_range;
					// ROM offsets count every byte, PRG and CRT stop at the limit
					cnt_step = in_range || (kind == loader_pkg::kind_rom);
					blk_mark = in_range && (kind == loader_pkg::kind_crt);
				end
				if (kind == loader_pkg::kind_rom) begin
					wr_addr = file_offset + loader_pkg::rom_base;
				end
			end
			st_fixup: begin
				wr_req  = !wr_busy;
				wr_addr = loader_pkg::fixup_addr[fix_idx];
				wr_data = fix_idx[0] ? load_addr[15:8] : load_addr[7:0];
			end
			default: begin
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// State register

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state   <= st_idle;
			kind    <= loader_pkg::kind_none;
			fix_idx <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (dl_active) begin
						kind <= decode_kind(dl_index);
						if (decode_kind(dl_index) inside {loader_pkg::kind_prg,
						                                  loader_pkg::kind_crt})
							state <= st_header;
						else
							state <= st_body;
					end
				end
				st_header, st_body: begin
					fix_idx <= '0;
					if (!dl_active)
						state <= (kind == loader_pkg::kind_prg) ? st_fixup : st_idle;
					else if (state == st_header && take && file_offset[0])
						state <= st_body;
				end
				st_fixup: begin
					// One pointer byte per completed bus cycle
					if (wr_req) begin
						fix_idx <= fix_idx + 1'b1;
						if (fix_idx == loader_pkg::num_fixups - 1)
							state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// File: hw/loader_pkg.sv
/*
 * Program loader shared definitions
 * Load kinds, download index codes, address limits, the kernal ROM window
 * and the zero page pointer table that is patched after a PRG load
 */

package loader_pkg;

	typedef logic [15:0] addr_t;
	typedef logic [7:0]  byte_t;

	typedef enum logic [1:0] {
		kind_none,
		kind_prg,
		kind_crt,
		kind_rom
	} load_kind_t;

	// Index byte sent by the host with each file
	localparam byte_t idx_prg = 8'h01;
	localparam byte_t idx_crt = 8'h41;
	localparam byte_t idx_rom = 8'h06;

	// First address a body may not write
	localparam addr_t prg_limit = 16'hA000;
	localparam addr_t crt_limit = 16'hC000;

	// Kernal image window inside the file and where it lands in memory
	localparam addr_t rom_lo   = 16'h4000;
	localparam addr_t rom_hi   = 16'h8000;
	localparam addr_t rom_base = 16'h8000;

	// BASIC pointers, even entries take the low byte of the end address
	localparam int    num_fixups = 8;
	localparam addr_t fixup_addr [num_fixups] = '{
		16'h002D, 16'h002E, 16'h002F, 16'h0030,
		16'h0031, 16'h0032, 16'h00AE, 16'h00AF
	};

	// Blocks 0 to 3 and block 5 of the 8 KB map
	localparam int num_blocks = 5;
	typedef logic [num_blocks-1:0] blk_mask_t;

endpackage

// File: hw/prg_loader_top.sv
/*
 * Program loader top level
 * Turns a host download stream into Wishbone byte writes and
 * cartridge block flags
 */

`timescale 1ns/1ps

module prg_loader_top #(
	parameter int ADDR_W = 16,
	parameter int DATA_W = 8
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  dl_active,
	input  loader_pkg::byte_t     dl_index,
	input  logic                  dl_valid,
	input  loader_pkg::byte_t     dl_data,
	output logic                  dl_busy,
	input  logic                  cart_writable,
	input  logic                  detach,
	output logic                  wb_cyc,
	output logic                  wb_stb,
	output logic                  wb_we,
	output logic [ADDR_W-1:0]     wb_adr,
	output logic [DATA_W-1:0]     wb_dat_w,
	input  logic                  wb_ack,
	output loader_pkg::blk_mask_t cart_blk,
	output loader_pkg::blk_mask_t cart_ro,
	output logic                  cart_reset
);

	loader_pkg::addr_t file_offset;
	loader_pkg::addr_t load_addr;
	logic              cnt_load_lo;
	logic              cnt_load_hi;
	logic              cnt_step;
	logic              cnt_start;
	logic              wr_req;
	loader_pkg::addr_t wr_addr;
	loader_pkg::byte_t wr_data;
	logic              wr_busy;
	logic              blk_mark;
	logic              crt_active;

	wb_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) wb_bus ();

	load_sequencer seq_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_active   (dl_active),
		.dl_index    (dl_index),
		.dl_valid    (dl_valid),
		.dl_data     (dl_data),
		.dl_busy     (dl_busy),
		.file_offset (file_offset),
		.load_addr   (load_addr),
		.cnt_load_lo (cnt_load_lo),
		.cnt_load_hi (cnt_load_hi),
		.cnt_step    (cnt_step),
		.cnt_start   (cnt_start),
		.wr_req      (wr_req),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.wr_busy     (wr_busy),
		.blk_mark    (blk_mark),
		.crt_active  (crt_active)
	);

	load_addr_counter cnt_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cnt_start   (cnt_start),
		.cnt_load_lo (cnt_load_lo),
		.cnt_load_hi (cnt_load_hi),
		.cnt_step    (cnt_step),
		.dl_data     (dl_data),
		.load_addr   (load_addr),
		.file_offset (file_offset)
	);

	cart_block_map blk_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.blk_mark      (blk_mark),
		.load_addr     (load_addr),
		.crt_active    (crt_active),
		.detach        (detach),
		.cart_writable (cart_writable),
		.cart_blk      (cart_blk),
		.cart_ro       (cart_ro),
		.cart_reset    (cart_reset)
	);

	wb_write_master wbm_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.wr_req  (wr_req),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.wr_busy (wr_busy),
		.bus     (wb_bus.master)
	);

	// Slave side of the bus leaves as plain ports
	assign wb_cyc     = wb_bus.cyc;
	assign wb_stb     = wb_bus.stb;
	assign wb_we      = wb_bus.we;
	assign wb_adr     = wb_bus.adr;
	assign wb_dat_w   = wb_bus.dat_w;
	assign wb_bus.ack = wb_ack;

endmodule

// File: hw/wb_if.sv
/*
 * Wishbone classic bus, write only
 * Single byte cycles from the loader to the core memory
 */

`timescale 1ns/1ps

interface wb_if #(
	parameter int ADDR_W = 16,
	parameter int DATA_W = 8
);

	logic              cyc;
	logic              stb;
	logic              we;
	logic [ADDR_W-1:0] adr;
	logic [DATA_W-1:0] dat_w;
	logic              ack;

	modport master (
		output cyc,
		output stb,
		output we,
		output adr,
		output dat_w,
		input  ack
	);

	modport slave (
		input  cyc,
		input  stb,
		input  we,
		input  adr,
		input  dat_w,
		output ack
	);

endinterface

// File: hw/wb_write_master.sv
/*
 * Wishbone classic write master
 * Latches one byte write and holds the bus cycle until the slave acks
 */

`timescale 1ns/1ps

module wb_write_master (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              wr_req,
	input  loader_pkg::addr_t wr_addr,
	input  loader_pkg::byte_t wr_data,
	output logic              wr_busy,
	wb_if.master              bus
);

	logic              cyc_q;
	loader_pkg::addr_t adr_q;
	loader_pkg::byte_t dat_q;
	logic              launch;

	// A new request is only taken while the bus is idle
	assign launch = wr_req && !cyc_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cyc_q <= 1'b0;
		end else if (cyc_q && bus.ack) begin
			cyc_q <= 1'b0;
		end else if (launch) begin
			cyc_q <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (launch) begin
			adr_q <= wr_addr;
			dat_q <= wr_data;
		end
	end

	// Classic cycle, cyc and stb move together and every cycle is a write
	assign bus.cyc   = cyc_q;
	assign bus.stb   = cyc_q;
	assign bus.we    = cyc_q;
	assign bus.adr   = adr_q;
	assign bus.dat_w = dat_q;

	assign wr_busy = cyc_q;

endmodule

// File: project.f
hw/loader_pkg.sv
hw/wb_if.sv
hw/load_sequencer.sv
hw/load_addr_counter.sv
hw/cart_block_map.sv
hw/wb_write_master.sv
hw/prg_loader_top.sv
tb/wb_mem_model.sv
tb/tb_prg_loader.sv

// File: tb/tb_prg_loader.sv
/*
 * Program loader testbench
 * Sends PRG, ROM and CRT files from a table and checks memory, the write log,
 * the cartridge block flags and the core reset hold
 */

`timescale 1ns/1ps

module tb_prg_loader;

	localparam int num_rows = 5;

	logic        clk_sys;
	logic        reset;
	logic        dl_active;
	logic [7:0]  dl_index;
	logic        dl_valid;
	logic [7:0]  dl_data;
	logic        dl_busy;
	logic        cart_writable;
	logic        detach;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [15:0] wb_adr;
	logic [7:0]  wb_dat_w;
	logic        wb_ack;
	logic [4:0]  cart_blk;
	logic [4:0]  cart_ro;
	logic        cart_reset;

	// File table, one row per download
	logic [7:0]  row_idx   [num_rows];
	logic [15:0] row_addr  [num_rows];
	int          row_len   [num_rows];
	logic        row_wr    [num_rows];
	logic [15:0] row_end   [num_rows];
	logic [4:0]  row_flags [num_rows];

	logic [7:0]  exp_mem  [0:65535];
	int          exp_hits [0:65535];
	int          exp_writes;
	int          errors;
	int          cycles;
	int          cycle_limit;

	prg_loader_top #(.ADDR_W(16), .DATA_W(8)) dut_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.dl_active     (dl_active),
		.dl_index      (dl_index),
		.dl_valid      (dl_valid),
		.dl_data       (dl_data),
		.dl_busy       (dl_busy),
		.cart_writable (cart_writable),
		.detach        (detach),
		.wb_cyc        (wb_cyc),
		.wb_stb        (wb_stb),
		.wb_we         (wb_we),
		.wb_adr        (wb_adr),
		.wb_dat_w      (wb_dat_w),
		.wb_ack        (wb_ack),
		.cart_blk      (cart_blk),
		.cart_ro       (cart_ro),
		.cart_reset    (cart_reset)
	);

	wb_mem_model mem_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.cyc     (wb_cyc),
		.stb     (wb_stb),
		.we      (wb_we),
		.adr     (wb_adr),
		.dat_w   (wb_dat_w),
		.ack     (wb_ack)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// Watchdog, the limit is set once the table is known
	initial begin
		cycles = 0;
		wait (cycle_limit > 0);
		while (cycles < cycle_limit) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout: the loader did not finish within %0d cycles", cycle_limit);
		$display("Simulation failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////
	// Table and expected values

	task automatic set_row(input int r, input logic [7:0] idx, input logic [15:0] addr,
	                       input int len, input logic wr, input logic [15:0] end_addr,
	                       input logic [4:0] flags);
		row_idx[r]   = idx;
		row_addr[r]  = addr;
		row_len[r]   = len;
		row_wr[r]    = wr;
		row_end[r]   = end_addr;
		row_flags[r] = flags;
	endtask

	task automatic build_table();
		set_row(0, loader_pkg::idx_prg, 16'h0801, 'h40, 1'b0, 16'h0841, 5'b00000);
		// Crosses the PRG limit, the last 16 bytes are dropped
		set_row(1, loader_pkg::idx_prg, 16'h9FF0, 'h20, 1'b0, 16'hA000, 5'b00000);
		set_row(2, loader_pkg::idx_rom, 16'h0000, 'h4010, 1'b0, 16'h0000, 5'b00000);
		set_row(3, loader_pkg::idx_crt, 16'h2000, 'h30, 1'b0, 16'h2030, 5'b00010);
		set_row(4, loader_pkg::idx_crt, 16'hA000, 'h30, 1'b1, 16'hA030, 5'b10010);
	endtask

	function automatic logic [7:0] fill_byte(input int a);
		fill_byte = a[7:0] ^ {a[11:8], a[15:12]} ^ 8'h3C;
	endfunction

	// File byte at offset o, PRG and CRT start with the load address
	function automatic logic [7:0] byte_at(input int r, input int o);
		int sum;
		sum = o + r;
		if (row_idx[r] != loader_pkg::idx_rom && o == 0)
			byte_at = row_addr[r][7:0];
		else if (row_idx[r] != loader_pkg::idx_rom && o == 1)
			byte_at = row_addr[r][15:8];
		else
			byte_at = sum[7:0];
	endfunction

	task automatic expect_write(input int a, input logic [7:0] v);
		exp_mem[a] = v;
		exp_hits[a]++;
		exp_writes++;
	endtask

	task automatic expect_file(input int r);
		int i;
		int a;
		int limit;
		if (row_idx[r] == loader_pkg::idx_rom) begin
			for (i = 0; i < row_len[r]; i++) begin
				if (i >= loader_pkg::rom_lo && i < loader_pkg::rom_hi) begin
					a = i + loader_pkg::rom_base;
					expect_write(a, byte_at(r, i));
				end
			end
		end else begin
			limit = (row_idx[r] == loader_pkg::idx_prg) ? loader_pkg::prg_limit :
			                                              loader_pkg::crt_limit;
			for (i = 0; i < row_len[r]; i++) begin
				a = row_addr[r] + i;
				if (a < limit)
					expect_write(a, byte_at(r, i + 2));
			end
			if (row_idx[r] == loader_pkg::idx_prg) begin
				for (i = 0; i < loader_pkg::num_fixups; i++) begin
					a = loader_pkg::fixup_addr[i];
					expect_write(a, (i % 2 == 1) ? row_end[r][15:8] : row_end[r][7:0]);
				end
			end
		end
	endtask

	//////////////////////////////////////////////////////////////
	// Stimulus and checks

	task automatic report_mismatch(input string name, input logic [31:0] got,
	                               input logic [31:0] exp);
		errors++;
		$display("ERR %0t ns %s got %h expected %h", $time, name, got, exp);
	endtask

	// Hold the byte until a clock edge sees dl_busy low
	task automatic send_byte(input logic [7:0] b);
		logic taken;
		dl_valid = 1'b1;
		dl_data  = b;
		taken    = 1'b0;
		while (!taken) begin
			@(negedge clk_sys);
			taken = !dl_busy;
			@(posedge clk_sys);
			#1;
		end
	endtask

	task automatic load_file(input int r);
		int n;
		int o;
		n = (row_idx[r] == loader_pkg::idx_rom) ? row_len[r] : row_len[r] + 2;
		@(posedge clk_sys);
		#1;
		cart_writable = row_wr[r];
		dl_index      = row_idx[r];
		dl_active     = 1'b1;
		for (o = 0; o < n; o++)
			send_byte(byte_at(r, o));
		dl_valid = 1'b0;
		@(negedge clk_sys);
		if (cart_reset !== (row_idx[r] == loader_pkg::idx_crt))
			report_mismatch("cart_reset", cart_reset, row_idx[r] == loader_pkg::idx_crt);
		@(posedge clk_sys);
		#1;
		dl_active = 1'b0;
		// Fixup starts one cycle after the download ends
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		while (dl_busy || wb_cyc)
			@(negedge clk_sys);
	endtask

	task automatic check_memory();
		int a;
		for (a = 0; a < 65536; a++) begin
			if (mem_i.mem[a] !== exp_mem[a])
				report_mismatch($sformatf("mem[%04h]", a), mem_i.mem[a], exp_mem[a]);
			if (mem_i.hits[a] != exp_hits[a])
				report_mismatch($sformatf("writes to %04h", a), mem_i.hits[a], exp_hits[a]);
		end
		if (mem_i.wr_count != exp_writes)
			report_mismatch("write count", mem_i.wr_count, exp_writes);
	endtask

	task automatic check_outputs(input int r);
		if (cart_blk !== row_flags[r])
			report_mismatch("cart_blk", cart_blk, row_flags[r]);
		if (cart_ro !== (row_wr[r] ? 5'b00000 : row_flags[r]))
			report_mismatch("cart_ro", cart_ro, row_wr[r] ? 5'b00000 : row_flags[r]);
		if (cart_reset !== 1'b0)
			report_mismatch("cart_reset", cart_reset, 1'b0);
	endtask

	// Detach in the middle of an open CRT download with the flags still set
	task automatic detach_test();
		logic [4:0] flags;
		flags = row_flags[num_rows-1];
		@(posedge clk_sys);
		#1;
		cart_writable = 1'b0;
		dl_index      = loader_pkg::idx_crt;
		dl_active     = 1'b1;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		if (cart_reset !== 1'b1)
			report_mismatch("cart_reset", cart_reset, 1'b1);
		if (cart_ro !== flags)
			report_mismatch("cart_ro", cart_ro, flags);
		@(posedge clk_sys);
		#1;
		detach = 1'b1;
		@(posedge clk_sys);
		#1;
		detach = 1'b0;
		@(negedge clk_sys);
		if (cart_blk !== 5'b00000)
			report_mismatch("cart_blk", cart_blk, 5'b00000);
		if (cart_ro !== 5'b00000)
			report_mismatch("cart_ro", cart_ro, 5'b00000);
		if (cart_reset !== 1'b0)
			report_mismatch("cart_reset", cart_reset, 1'b0);
		@(posedge clk_sys);
		#1;
		dl_active = 1'b0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		if (cart_reset !== 1'b0)
			report_mismatch("cart_reset", cart_reset, 1'b0);
	endtask

	initial begin
		int r;
		int a;
		int total;
		reset         = 1'b1;
		dl_active     = 1'b0;
		dl_index      = 8'h00;
		dl_valid      = 1'b0;
		dl_data       = 8'h00;
		cart_writable = 1'b0;
		detach        = 1'b0;
		errors        = 0;
		exp_writes    = 0;
		build_table();
		total = 0;
		for (r = 0; r < num_rows; r++)
			total += (row_idx[r] == loader_pkg::idx_rom) ? row_len[r] : row_len[r] + 2;
		cycle_limit = 5 * total + 200 * num_rows;
		for (a = 0; a < 65536; a++) begin
			exp_mem[a]  = fill_byte(a);
			exp_hits[a] = 0;
		end

		repeat (2) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		@(negedge clk_sys);
		if (wb_cyc !== 1'b0)
			report_mismatch("wb_cyc", wb_cyc, 1'b0);
		if (wb_stb !== 1'b0)
			report_mismatch("wb_stb", wb_stb, 1'b0);
		if (dl_busy !== 1'b0)
			report_mismatch("dl_busy", dl_busy, 1'b0);
		if (cart_reset !== 1'b0)
			report_mismatch("cart_reset", cart_reset, 1'b0);
		if (cart_blk !== 5'b00000)
			report_mismatch("cart_blk", cart_blk, 5'b00000);

		for (r = 0; r < num_rows; r++) begin
			expect_file(r);
			load_file(r);
			check_memory();
			check_outputs(r);
		end
		detach_test();

		$display("Files loaded: %0d, bus writes: %0d, errors: %0d",
		         num_rows, mem_i.wr_count, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: tb/wb_mem_model.sv
/*
 * Wishbone slave memory for the loader testbench
 * 64 KB of bytes, a random 0 to 3 cycle ack delay and a per address write log
 */

`timescale 1ns/1ps

module wb_mem_model (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        cyc,
	input  logic        stb,
	input  logic        we,
	input  logic [15:0] adr,
	input  logic [7:0]  dat_w,
	output logic        ack
);

	logic [7:0] mem [0:65535];
	int         hits [0:65535];
	int         wr_count;
	integer     seed;
	integer     rnd;
	logic [1:0] delay;
	logic [1:0] wait_left;
	logic       started;

	function automatic logic [7:0] fill_byte(input int a);
		fill_byte = a[7:0] ^ {a[11:8], a[15:12]} ^ 8'h3C;
	endfunction

	initial begin
		seed     = 32'h700d;
		wr_count = 0;
		ack      = 1'b0;
		for (int a = 0; a < 65536; a++) begin
			mem[a]  = fill_byte(a);
			hits[a] = 0;
		end
	end

	// Store the byte and log it in the same edge that raises ack
	task automatic finish_cycle();
		ack <= 1'b1;
		if (we) begin
			mem[adr]  <= dat_w;
			hits[adr] <= hits[adr] + 1;
			wr_count  <= wr_count + 1;
		end
	endtask

	always @(posedge clk_sys) begin
		if (reset) begin
			ack       <= 1'b0;
			started   <= 1'b0;
			wait_left <= 2'd0;
		end else begin
			ack <= 1'b0;
			if (cyc && stb && !ack) begin
				if (!started) begin
					rnd   = $random(seed);
					delay = rnd[1:0];
					if (delay == 2'd0) begin
						finish_cycle();
					end else begin
						started   <= 1'b1;
						wait_left <= delay - 2'd1;
					end
				end else if (wait_left == 2'd0) begin
					started <= 1'b0;
					finish_cycle();
				end else begin
					wait_left <= wait_left - 2'd1;
				end
			end
		end
	end

endmodule
